// File: Makefile
SRCS = $(shell grep -v '^+' cpu.f) include/cpu_settings.svh

obj_dir/Vcpu_tb: $(SRCS) cpu.f
	verilator --binary --timing --assert -f cpu.f --top-module cpu_tb

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: cpu.f
+incdir+include
design/cpu_pkg.sv
design/alu.sv
design/regfile.sv
design/fetch_unit.sv
design/execute_stage.sv
design/mem_stage.sv
design/cpu.sv
testbench/cpu_asserts.sv
testbench/cpu_tb.sv

// File: design/alu.sv
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  alu_func_t   func,
	output logic [31:0] result
);
	logic [31:0] sum;
	logic [31:0] diff;
	logic        less;

	// sum also serves addi and load/store addresses
	assign sum = a + b;
	assign diff = a - b;
	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (func)
			FN_ADD: result = sum;
			FN_SUB: result = diff;
			FN_AND: result = a & b;
			FN_OR: result = a | b;
			FN_XOR: result = a ^ b;
			FN_SLT: result = {31'd0, less};
			FN_SLL: result = a << b[4:0];
			FN_SRL: result = a >> b[4:0];
			default: result = 32'd0;
		endcase
	end

endmodule

// File: design/cpu.sv
`timescale 1ns/100ps

module cpu import cpu_pkg::*; (
	input  logic        clock,
	input  logic        rst,
	output logic        im_req_valid,
	output mem_req_t    im_req,
	input  logic        im_req_ready,
	input  logic        im_resp_valid,
	input  logic [31:0] im_resp_rdata,
	output logic        dm_req_valid,
	output mem_req_t    dm_req,
	input  logic        dm_req_ready,
	input  logic        dm_resp_valid,
	input  logic [31:0] dm_resp_rdata,
	output logic        halted
);
	// fetch to execute
	logic         f_valid;
	fetch_word_t  f_word;
	logic         f_ready;
	logic         redirect;
	logic [31:0]  redirect_pc;

	// register reads
	logic [4:0]   ra_addr;
	logic [4:0]   rb_addr;
	logic [31:0]  ra_data;
	logic [31:0]  rb_data;

	// execute to memory
	logic         x_valid;
	exec_result_t x_item;
	logic         x_ready;

	// writeback, doubles as forwarding source
	logic         wb_valid;
	logic [4:0]   wb_rd;
	logic [31:0]  wb_data;
	logic         load_pending;
	logic [4:0]   load_rd;

	fetch_unit i_fetch (
		.clock(clock),
		.rst(rst),
		.halted(halted),
		.im_req_valid(im_req_valid),
		.im_req(im_req),
		.im_req_ready(im_req_ready),
		.im_resp_valid(im_resp_valid),
		.im_resp_rdata(im_resp_rdata),
		.f_valid(f_valid),
		.f_word(f_word),
		.f_ready(f_ready),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

	regfile i_regfile (
		.clock(clock),
		.rst(rst),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.we(wb_valid),
		.wr_addr(wb_rd),
		.wr_data(wb_data)
	);

	execute_stage i_execute (
		.clock(clock),
		.rst(rst),
		.f_valid(f_valid),
		.f_word(f_word),
		.f_ready(f_ready),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.load_pending(load_pending),
		.load_rd(load_rd),
		.x_valid(x_valid),
		.x_item(x_item),
		.x_ready(x_ready),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

	mem_stage i_mem (
		.clock(clock),
		.rst(rst),
		.x_valid(x_valid),
		.x_item(x_item),
		.x_ready(x_ready),
		.dm_req_valid(dm_req_valid),
		.dm_req(dm_req),
		.dm_req_ready(dm_req_ready),
		.dm_resp_valid(dm_resp_valid),
		.dm_resp_rdata(dm_resp_rdata),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.load_pending(load_pending),
		.load_rd(load_rd),
		.halted(halted)
	);

endmodule

// File: design/cpu_pkg.sv
package cpu_pkg;

	// unlisted opcodes run as no-ops
	typedef enum logic [5:0] {
		OP_ALU  = 6'h00,
		OP_ADDI = 6'h01,
		OP_LW   = 6'h02,
		OP_SW   = 6'h03,
		OP_BEQ  = 6'h04,
		OP_BNE  = 6'h05,
		OP_HALT = 6'h3f
	} opcode_t;

	typedef enum logic [3:0] {
		FN_ADD = 4'h0,
		FN_SUB = 4'h1,
		FN_AND = 4'h2,
		FN_OR  = 4'h3,
		FN_XOR = 4'h4,
		FN_SLT = 4'h5,
		FN_SLL = 4'h6,
		FN_SRL = 4'h7
	} alu_func_t;

	typedef struct packed {
		opcode_t     opcode;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [10:0] func;
	} instr_reg_t;

	typedef struct packed {
		opcode_t     opcode;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [15:0] imm;
	} instr_imm_t;

	// same word, two field layouts
	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_t;

	typedef struct packed {
		logic [31:0] pc;
		instr_t      instr;
	} fetch_word_t;

	typedef struct packed {
		logic        is_load;
		logic        is_store;
		logic        is_halt;
		logic        writes_reg;
		logic [4:0]  rd;
		logic [31:0] result;
		logic [31:0] store_data;
	} exec_result_t;

	typedef struct packed {
		logic [31:0] addr;
		logic        write;
		logic [31:0] wdata;
	} mem_req_t;

endpackage

// File: design/execute_stage.sv
`timescale 1ns/100ps

module execute_stage import cpu_pkg::*; (
	input  logic         clock,
	input  logic         rst,
	input  logic         f_valid,
	input  fetch_word_t  f_word,
	output logic         f_ready,
	output logic [4:0]   ra_addr,
	output logic [4:0]   rb_addr,
	input  logic [31:0]  ra_data,
	input  logic [31:0]  rb_data,
	input  logic         wb_valid,
	input  logic [4:0]   wb_rd,
	input  logic [31:0]  wb_data,
	input  logic         load_pending,
	input  logic [4:0]   load_rd,
	output logic         x_valid,
	output exec_result_t x_item,
	input  logic         x_ready,
	output logic         redirect,
	output logic [31:0]  redirect_pc
);
	instr_t       instr;
	opcode_t      op;
	logic         is_alu;
	logic         is_addi;
	logic         is_load;
	logic         is_store;
	logic         is_beq;
	logic         is_bne;
	logic         is_halt;
	logic         uses_a;
	logic         uses_b;
	logic         writes_rt;
	logic [31:0]  imm_ext;
	logic [31:0]  a_val;
	logic [31:0]  b_val;
	logic [31:0]  alu_b;
	alu_func_t    func;
	logic [31:0]  alu_result;
	logic         hit_x;
	logic         hit_load;
	logic         take;
	logic         taken;
	logic         produces;
	exec_result_t next_item;

	assign instr = f_word.instr;
	assign op = instr.r.opcode;
	assign is_alu = (op == OP_ALU);
	assign is_addi = (op == OP_ADDI);
	assign is_load = (op == OP_LW);
	assign is_store = (op == OP_SW);
	assign is_beq = (op == OP_BEQ);
	assign is_bne = (op == OP_BNE);
	assign is_halt = (op == OP_HALT);

	// port b reads rb in register form, rt for stores and branches
	assign ra_addr = instr.r.ra;
	assign rb_addr = is_alu ? instr.r.rb : instr.r.rt;

	assign uses_a = is_alu || is_addi || is_load || is_store || is_beq || is_bne;
	assign uses_b = is_alu || is_store || is_beq || is_bne;
	assign writes_rt = (is_alu || is_addi || is_load) && (instr.r.rt != 5'd0);

	assign a_val = (wb_valid && wb_rd == ra_addr) ? wb_data : ra_data;
	assign b_val = (wb_valid && wb_rd == rb_addr) ? wb_data : rb_data;

	// producer still in our own output register, not yet written back
	assign hit_x = x_valid && x_item.writes_reg &&
		((uses_a && ra_addr == x_item.rd) || (uses_b && rb_addr == x_item.rd));
	assign hit_load = load_pending &&
		((uses_a && ra_addr == load_rd) || (uses_b && rb_addr == load_rd));

	assign f_ready = (!x_valid || x_ready) && !hit_x && !hit_load;
	assign take = f_valid && f_ready;

	assign imm_ext = {{16{instr.i.imm[15]}}, instr.i.imm};
	assign func = is_alu ? alu_func_t'(instr.r.func[3:0]) : FN_ADD;
	assign alu_b = is_alu ? b_val : imm_ext;

	alu i_alu (
		.a(a_val),
		.b(alu_b),
		.func(func),
		.result(alu_result)
	);

	assign taken = (is_beq && a_val == b_val) || (is_bne && a_val != b_val);
	assign redirect = take && taken;
	// word offset relative to the next instruction
	assign redirect_pc = f_word.pc + 32'd4 + {imm_ext[29:0], 2'b00};

	// branches and no-ops end here
	assign produces = is_alu || is_addi || is_load || is_store || is_halt;

	assign next_item.is_load = is_load;
	assign next_item.is_store = is_store;
	assign next_item.is_halt = is_halt;
	assign next_item.writes_reg = writes_rt;
	assign next_item.rd = instr.r.rt;
	assign next_item.result = alu_result;
	assign next_item.store_data = b_val;

	always_ff @(posedge clock) begin
		if (rst)
			x_valid <= 1'b0;
		else if (take)
			x_valid <= produces;
		else if (x_ready)
			x_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (take)
			x_item <= next_item;
	end

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module fetch_unit import cpu_pkg::*; (
	input  logic        clock,
	input  logic        rst,
	input  logic        halted,
	output logic        im_req_valid,
	output mem_req_t    im_req,
	input  logic        im_req_ready,
	input  logic        im_resp_valid,
	input  logic [31:0] im_resp_rdata,
	output logic        f_valid,
	output fetch_word_t f_word,
	input  logic        f_ready,
	input  logic        redirect,
	input  logic [31:0] redirect_pc
);
	logic [31:0] pc;
	logic [31:0] req_addr;
	logic        busy;
	logic        stopped;
	logic        accept;
	logic        handoff;
	logic        resp_in;
	logic        can_issue;

	assign accept = im_req_valid && im_req_ready;
	assign handoff = f_valid && f_ready;
	assign resp_in = im_resp_valid && busy;
	// next fetch only once the held word has gone to execute
	assign can_issue = !im_req_valid && !busy && !f_valid && !stopped && !halted;

	assign im_req.addr = req_addr;
	assign im_req.write = 1'b0;
	assign im_req.wdata = '0;

	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= `CPU_RESET_PC;
			im_req_valid <= 1'b0;
			busy <= 1'b0;
			stopped <= 1'b0;
			f_valid <= 1'b0;
		end else begin
			if (can_issue) begin
				im_req_valid <= 1'b1;
				pc <= pc + 32'd4;
			end else if (accept) begin
				im_req_valid <= 1'b0;
			end
			if (redirect)
				pc <= redirect_pc;

			if (accept)
				busy <= 1'b1;
			else if (resp_in)
				busy <= 1'b0;

			// a taken branch is a handoff, so the held word leaves with it
			if (resp_in)
				f_valid <= 1'b1;
			else if (handoff)
				f_valid <= 1'b0;

			if (handoff && f_word.instr.r.opcode == OP_HALT)
				stopped <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (can_issue)
			req_addr <= pc;
		if (resp_in) begin
			f_word.pc <= req_addr;
			f_word.instr <= im_resp_rdata;
		end
	end

endmodule

// File: design/mem_stage.sv
`timescale 1ns/100ps

module mem_stage import cpu_pkg::*; (
	input  logic         clock,
	input  logic         rst,
	input  logic         x_valid,
	input  exec_result_t x_item,
	output logic         x_ready,
	output logic         dm_req_valid,
	output mem_req_t     dm_req,
	input  logic         dm_req_ready,
	input  logic         dm_resp_valid,
	input  logic [31:0]  dm_resp_rdata,
	output logic         wb_valid,
	output logic [4:0]   wb_rd,
	output logic [31:0]  wb_data,
	output logic         load_pending,
	output logic [4:0]   load_rd,
	output logic         halted
);
	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_WAIT
	} state_t;

	state_t       state;
	exec_result_t item;
	logic         alu_wb;
	logic         accept;
	logic         load_done;

	assign x_ready = (state == S_IDLE);
	assign accept = x_valid && x_ready;

	assign dm_req_valid = (state == S_REQ);
	assign dm_req.addr = item.result;
	assign dm_req.write = item.is_store;
	assign dm_req.wdata = item.store_data;

	// load data goes straight to the register file on the response
	assign load_done = (state == S_WAIT) && dm_resp_valid && item.is_load && item.writes_reg;
	assign wb_valid = alu_wb || load_done;
	assign wb_rd = item.rd;
	assign wb_data = alu_wb ? item.result : dm_resp_rdata;

	assign load_pending = (state != S_IDLE) && item.is_load && item.writes_reg && !load_done;
	assign load_rd = item.rd;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= S_IDLE;
			alu_wb <= 1'b0;
			halted <= 1'b0;
		end else begin
			alu_wb <= accept && x_item.writes_reg && !x_item.is_load;
			case (state)
				S_IDLE: begin
					if (accept && (x_item.is_load || x_item.is_store))
						state <= S_REQ;
					if (accept && x_item.is_halt)
						halted <= 1'b1;
				end
				S_REQ: begin
					if (dm_req_ready)
						state <= S_WAIT;
				end
				S_WAIT: begin
					// stores are acknowledged too
					if (dm_resp_valid)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept)
			item <= x_item;
	end

endmodule

// File: design/regfile.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module regfile (
	input  logic        clock,
	input  logic        rst,
	input  logic [4:0]  ra_addr,
	input  logic [4:0]  rb_addr,
	output logic [31:0] ra_data,
	output logic [31:0] rb_data,
	input  logic        we,
	input  logic [4:0]  wr_addr,
	input  logic [31:0] wr_data
);
	logic [31:0] regs [`CPU_REG_COUNT];

	// reads see the value from before this cycle's write
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (we && wr_addr != 5'd0) begin
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

// File: include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// first fetch address out of reset
`define CPU_RESET_PC 32'h0000_0000

// architectural registers, r0 reads as zero
`define CPU_REG_COUNT 32

// cycles before the testbench gives up on a wait
`define CPU_WAIT_LIMIT 5000

`endif

// File: testbench/cpu_asserts.sv
`timescale 1ns/100ps

module cpu_asserts import cpu_pkg::*; (
	input logic     clock,
	input logic     rst,
	input logic     req_valid,
	input mem_req_t req,
	input logic     req_ready,
	input logic     resp_valid,
	input logic     halted
);
	logic outstanding;

	// one request in flight until its response
	always_ff @(posedge clock) begin
		if (rst)
			outstanding <= 1'b0;
		else if (req_valid && req_ready)
			outstanding <= 1'b1;
		else if (resp_valid)
			outstanding <= 1'b0;
	end

	a_req_hold: assert property (@(posedge clock) disable iff (rst)
		req_valid && !req_ready |=> req_valid && $stable(req))
		else $error("request dropped or changed before acceptance");

	a_single: assert property (@(posedge clock) disable iff (rst)
		outstanding |-> !req_valid)
		else $error("second request made while a response is outstanding");

	a_halt_sticky: assert property (@(posedge clock) disable iff (rst)
		halted |=> halted)
		else $error("halted fell without reset");

endmodule

bind mem_stage cpu_asserts i_dm_asserts (
	.clock(clock), .rst(rst), .req_valid(dm_req_valid), .req(dm_req),
	.req_ready(dm_req_ready), .resp_valid(dm_resp_valid), .halted(halted)
);

bind fetch_unit cpu_asserts i_im_asserts (
	.clock(clock), .rst(rst), .req_valid(im_req_valid), .req(im_req),
	.req_ready(im_req_ready), .resp_valid(im_resp_valid), .halted(halted)
);

// File: testbench/cpu_tb.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_tb import cpu_pkg::*; ();
	logic        clock = 1'b0;
	logic        rst = 1'b1;
	logic        im_req_valid;
	mem_req_t    im_req;
	logic        im_req_ready = 1'b0;
	logic        im_resp_valid = 1'b0;
	logic [31:0] im_resp_rdata = '0;
	logic        dm_req_valid;
	mem_req_t    dm_req;
	logic        dm_req_ready = 1'b0;
	logic        dm_resp_valid = 1'b0;
	logic [31:0] dm_resp_rdata = '0;
	logic        halted;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] got_addr [$];
	logic [31:0] got_data [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	int          seed = 32'ha9e2;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	logic        bp_mode = 1'b0;
	logic        im_acc = 1'b0;
	logic        dm_acc = 1'b0;
	logic [31:0] im_addr;
	logic [31:0] dm_rdata;
	logic [31:0] first_im_addr;
	logic        seen_im = 1'b0;
	int          accepts_after = 0;
	int          im_cnt = 0;
	int          dm_cnt = 0;
	int          im_stall = 0;
	int          dm_stall = 0;

	cpu i_dut (.*);

	always #5 clock = ~clock;

	function automatic int rnd(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [31:0] fill(int i);
		return (32'h0101_0101 * 32'(i)) ^ 32'h5a5a_a5a5;
	endfunction

	function automatic logic [31:0] enc_reg(logic [4:0] rt, logic [4:0] ra, logic [4:0] rb,
			logic [3:0] fn);
		return {OP_ALU, rt, ra, rb, 7'd0, fn};
	endfunction

	function automatic logic [31:0] enc_imm(opcode_t op, logic [4:0] rt, logic [4:0] ra,
			logic [15:0] imm);
		return {op, rt, ra, imm};
	endfunction

	function automatic logic [31:0] alu_ref(logic [31:0] a, logic [31:0] b, logic [3:0] fn);
		case (fn)
			4'h0: return a + b;
			4'h1: return a - b;
			4'h2: return a & b;
			4'h3: return a | b;
			4'h4: return a ^ b;
			4'h5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			4'h6: return a << b[4:0];
			4'h7: return a >> b[4:0];
			default: return 32'd0;
		endcase
	endfunction

	task automatic check(string sig, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", sig, got, exp);
			errors++;
		end
	endtask

	// long low stretches only in back-pressure mode
	task automatic next_ready(inout int stall, output logic rdy);
		if (stall > 0) begin
			stall--;
			rdy = 1'b0;
		end else if (bp_mode && rnd(8) == 0) begin
			stall = 5 + rnd(20);
			rdy = 1'b0;
		end else begin
			rdy = (rnd(4) != 0);
		end
	endtask

	// acceptance is sampled on the rising edge
	always @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < 256; i++)
				dmem[i] = fill(i);
			got_addr.delete();
			got_data.delete();
			seen_im = 1'b0;
			accepts_after = 0;
			im_acc = 1'b0;
			dm_acc = 1'b0;
		end else begin
			im_acc = im_req_valid && im_req_ready;
			dm_acc = dm_req_valid && dm_req_ready;
			if (im_acc) begin
				check("im_req.write", 32'(im_req.write), 32'd0);
				im_addr = im_req.addr;
				if (!seen_im)
					first_im_addr = im_req.addr;
				seen_im = 1'b1;
			end
			if (dm_acc) begin
				dm_rdata = dmem[dm_req.addr[9:2]];
				if (dm_req.write) begin
					got_addr.push_back(dm_req.addr);
					got_data.push_back(dm_req.wdata);
					dmem[dm_req.addr[9:2]] = dm_req.wdata;
				end
			end
			if (halted && (im_acc || dm_acc))
				accepts_after++;
		end
	end

	// memory responders, 1 to 4 cycles after acceptance
	always @(negedge clock) begin
		im_resp_valid = 1'b0;
		dm_resp_valid = 1'b0;
		if (rst) begin
			im_cnt = 0;
			dm_cnt = 0;
			im_stall = 0;
			dm_stall = 0;
			im_req_ready = 1'b0;
			dm_req_ready = 1'b0;
		end else begin
			if (im_acc)
				im_cnt = 1 + rnd(4);
			if (im_cnt > 0) begin
				im_cnt--;
				if (im_cnt == 0) begin
					im_resp_valid = 1'b1;
					im_resp_rdata = imem[im_addr[9:2]];
				end
			end
			if (dm_acc)
				dm_cnt = 1 + rnd(4);
			if (dm_cnt > 0) begin
				dm_cnt--;
				if (dm_cnt == 0) begin
					dm_resp_valid = 1'b1;
					dm_resp_rdata = dm_rdata;
				end
			end
			next_ready(im_stall, im_req_ready);
			next_ready(dm_stall, dm_req_ready);
		end
	end

	// kind 0 alu/store mix, 1 store/load/use chains, 2 with forward branches
	task automatic gen_program(int kind);
		int pos;
		logic [4:0] rt;
		logic [4:0] ld;
		logic [15:0] off;
		for (int i = 0; i < 256; i++)
			imem[i] = {OP_HALT, 26'(i)};
		imem[0] = enc_imm(OP_ADDI, 5'd31, 5'd0, 16'd64);
		for (int r = 1; r < 8; r++)
			imem[r] = enc_imm(OP_ADDI, 5'(r), 5'(rnd(8)), 16'(rnd(65536)));
		pos = 8;
		while (pos < 48) begin
			rt = 5'(rnd(8));
			off = 16'(4 * rnd(32));
			if (kind == 1) begin
				ld = 5'(1 + rnd(7));
				imem[pos] = enc_imm(OP_SW, rt, 5'd31, off);
				imem[pos + 1] = enc_imm(OP_LW, ld, 5'd31, 16'(4 * rnd(32)));
				imem[pos + 2] = enc_reg(rt, ld, 5'(rnd(8)), 4'(rnd(8)));
				imem[pos + 3] = enc_imm(OP_SW, rt, 5'd31, off);
				pos += 4;
			end else if (kind == 2 && rnd(4) == 0 && pos < 44) begin
				imem[pos] = enc_imm(rnd(2) != 0 ? OP_BEQ : OP_BNE, 5'(rnd(3)), 5'(rnd(3)),
					16'(1 + rnd(3)));
				pos++;
			end else begin
				case (rnd(3))
					0: imem[pos] = enc_reg(rt, 5'(rnd(8)), 5'(rnd(8)), 4'(rnd(8)));
					1: imem[pos] = enc_imm(OP_ADDI, rt, 5'(rnd(8)), 16'(rnd(65536)));
					default: imem[pos] = enc_imm(OP_SW, rt, 5'd31, off);
				endcase
				pos++;
			end
		end
		imem[pos] = {OP_HALT, 26'd0};
	endtask

	task automatic run_model();
		logic [31:0] r [32];
		logic [31:0] md [256];
		logic [31:0] pc;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [31:0] next_pc;
		int steps;
		for (int i = 0; i < 32; i++)
			r[i] = '0;
		for (int i = 0; i < 256; i++)
			md[i] = fill(i);
		exp_addr.delete();
		exp_data.delete();
		pc = `CPU_RESET_PC;
		steps = 0;
		while (steps < 1000) begin
			w = imem[pc[9:2]];
			a = r[w[20:16]];
			b = r[w[25:21]];
			imm = {{16{w[15]}}, w[15:0]};
			addr = a + imm;
			next_pc = pc + 32'd4;
			steps++;
			if (w[31:26] == OP_HALT)
				break;
			case (w[31:26])
				OP_ALU: r[w[25:21]] = alu_ref(a, r[w[15:11]], w[3:0]);
				OP_ADDI: r[w[25:21]] = addr;
				OP_LW: r[w[25:21]] = md[addr[9:2]];
				OP_SW: begin
					md[addr[9:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				OP_BEQ: if (a == b) next_pc = pc + 32'd4 + (imm << 2);
				OP_BNE: if (a != b) next_pc = pc + 32'd4 + (imm << 2);
				default: ;
			endcase
			r[0] = '0;
			pc = next_pc;
		end
	endtask

	task automatic do_reset();
		@(negedge clock);
		rst = 1'b1;
		repeat (16) begin
			@(negedge clock);
			check("dm_req_valid", 32'(dm_req_valid), 32'd0);
			check("halted", 32'(halted), 32'd0);
		end
		rst = 1'b0;
		@(negedge clock);
		check("dm_req_valid", 32'(dm_req_valid), 32'd0);
		check("halted", 32'(halted), 32'd0);
	endtask

	task automatic finish_test(string name, int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic run_program(string name, logic bp);
		int start;
		int waited;
		start = errors;
		bp_mode = bp;
		run_model();
		do_reset();
		waited = 0;
		while (!halted && waited < `CPU_WAIT_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (!halted) begin
			$display("timeout: the core never halted in test %s", name);
			errors++;
		end else begin
			check("store count", got_addr.size(), exp_addr.size());
			for (int i = 0; i < got_addr.size() && i < exp_addr.size(); i++) begin
				check("dm_req.addr", got_addr[i], exp_addr[i]);
				check("dm_req.wdata", got_data[i], exp_data[i]);
			end
		end
		finish_test(name, start);
	endtask

	initial begin
		int start;
		int waited;
		gen_program(0);
		start = errors;
		do_reset();
		waited = 0;
		while (!seen_im && waited < `CPU_WAIT_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (!seen_im) begin
			$display("timeout: no instruction fetch was accepted after reset");
			errors++;
		end else begin
			check("im_req.addr", first_im_addr, `CPU_RESET_PC);
		end
		finish_test("reset", start);

		run_program("alu_store", 1'b0);
		run_program("back_pressure", 1'b1);

		// nothing may be accepted once halted
		start = errors;
		repeat (32) @(negedge clock);
		check("halted", 32'(halted), 32'd1);
		check("accepts after halt", 32'(accepts_after), 32'd0);
		finish_test("halt", start);

		gen_program(1);
		run_program("loads", 1'b0);
		gen_program(2);
		run_program("branches", 1'b0);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
